// ==== game_pkg.sv ====
// Game identity, download indices and DIP bank types shared by the capture, matrix and mixer
package game_pkg;

	// ====================
	// Game select codes
	// ====================

	// Raw byte written by the host on the game index
	typedef logic [7:0] game_code_t;

	// Nothing loaded yet
	localparam game_code_t GAME_NONE      = 8'd0;
	localparam game_code_t GAME_SPACEZAP  = 8'd3;
	localparam game_code_t GAME_GORF      = 8'd4;
	localparam game_code_t GAME_WOW       = 8'd5;
	localparam game_code_t GAME_ROBBY     = 8'd6;
	// Program 1 set of Gorf, runs as plain Gorf on this board
	localparam game_code_t GAME_GORF_PRG1 = 8'd7;

	// One-hot game flags
	// All members stay clear for an unknown or missing code
	typedef struct packed {
		logic spacezap;
		logic gorf;
		logic wow;
		logic robby;
	} game_flags_t;

	// ====================
	// Host download
	// ====================

	// Index carrying the game-select byte
	localparam logic [7:0] IDX_GAME = 8'd1;
	// Index carrying the DIP-switch bytes
	localparam logic [7:0] IDX_DIP  = 8'd254;

	// ====================
	// DIP bank
	// ====================

	localparam int DIP_COUNT = 8;

	typedef logic [7:0] dip_byte_t;
	typedef dip_byte_t [DIP_COUNT-1:0] dip_bank_t;

	// Cabinet options, bit 0 selects the Gorf cabinet speaker layout
	localparam int DIP_CAB   = 0;
	// Coinage and game options
	localparam int DIP_COIN  = 2;
	// Read back directly on column 3
	localparam int DIP_EXTRA = 3;

endpackage

// ==== io_pkg.sv ====
// Player, host download and audio types plus switch-matrix strobe codes for the I/O block
package io_pkg;

	// ====================
	// Host writes
	// ====================

	// Single-cycle write strobe with its index, address and data byte
	typedef struct packed {
		logic        wr;
		logic [7:0]  index;
		logic [18:0] addr;
		logic [7:0]  data;
	} download_t;

	// One player's controls, active high as they come from the host
	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic fire;
		logic fire2;
		logic start;
		logic coin;
	} player_t;

	// ====================
	// Switch matrix
	// ====================

	// One-hot column strobes driven by the game CPU
	localparam logic [7:0] COL_0 = 8'h01;
	localparam logic [7:0] COL_1 = 8'h02;
	localparam logic [7:0] COL_2 = 8'h04;
	localparam logic [7:0] COL_3 = 8'h08;
	// Nothing pressed on any row
	localparam logic [7:0] ROW_IDLE = 8'hFF;

	// Unsigned stereo pair
	typedef struct packed {
		logic [15:0] left;
		logic [15:0] right;
	} audio_pair_t;

	// Lifts chip audio toward the sample silence level on the cabinet
	localparam logic [16:0] CAB_OFFSET = 17'd16384;
	// Ceiling for the offset channel
	localparam logic [16:0] AUDIO_MAX  = 17'd65535;

endpackage

// ==== download_capture.sv ====
// Input side, latches the game code and DIP bytes from host writes and decodes game flags
`timescale 1ns/1ps

module download_capture (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  io_pkg::download_t     dl,
	output game_pkg::game_flags_t flags,
	output game_pkg::dip_bank_t   dips
);
	import game_pkg::*;

	game_code_t  game_code;
	game_flags_t flags_next;
	logic        game_wr;
	logic        dip_wr;

	// ====================
	// Write decode
	// ====================

	// Game byte arrives on its own index, any address
	assign game_wr = dl.wr && (dl.index == IDX_GAME);

	// DIP bytes only land for addresses inside the bank
	assign dip_wr = dl.wr && (dl.index == IDX_DIP) && (dl.addr < 19'(DIP_COUNT));

	// Game code register
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			game_code <= GAME_NONE;
		end else if (game_wr) begin
			game_code <= dl.data;
		end
	end

	// DIP bank, one byte per write
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			dips <= '0;
		end else if (dip_wr) begin
			dips[dl.addr[2:0]] <= dl.data;
		end
	end

	// ====================
	// Flag decode
	// ====================

	// One-hot per kept game
	// Program 1 Gorf shares the Gorf flag
	always_comb begin
		flags_next = '0;
		case (game_code)
			GAME_SPACEZAP: flags_next.spacezap = 1'b1;
			GAME_GORF,
			GAME_GORF_PRG1: flags_next.gorf = 1'b1;
			GAME_WOW: flags_next.wow = 1'b1;
			GAME_ROBBY: flags_next.robby = 1'b1;
			// Unknown or dropped games leave every flag clear
			default: flags_next = '0;
		endcase
	end

	// Second stage, flags follow the code one edge later
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			flags <= '0;
		end else begin
			flags <= flags_next;
		end
	end

endmodule

// ==== switch_matrix.sv ====
// Processing part, builds the row byte the game CPU reads for each column strobe
`timescale 1ns/1ps

module switch_matrix (
	input  game_pkg::game_flags_t flags,
	input  game_pkg::dip_bank_t   dips,
	input  io_pkg::player_t       p1,
	input  io_pkg::player_t       p2,
	input  logic                  speech_busy,
	input  logic [7:0]            col_select,
	output logic [7:0]            row_data
);
	import game_pkg::*;
	import io_pkg::*;

	dip_byte_t  dip_coin;
	logic [4:0] p1_stick;
	logic [4:0] p2_stick;
	logic [7:0] col0_byte;
	logic [7:0] col1_byte;
	logic [7:0] col2_byte;
	logic       any_game;

	// Fire and four directions, active low as the CPU sees them
	// Bit order is fire, right, left, down, up
	function automatic logic [4:0] stick_bits(input player_t p);
		return {~p.fire, ~p.right, ~p.left, ~p.down, ~p.up};
	endfunction

	assign dip_coin = dips[DIP_COIN];
	assign p1_stick = stick_bits(p1);
	assign p2_stick = stick_bits(p2);

	// Column 3 is only live once a kept game is selected
	assign any_game = |flags;

	// ====================
	// Per-game columns
	// ====================

	always_comb begin
		// No game, every row reads as released
		col0_byte = ROW_IDLE;
		col1_byte = ROW_IDLE;
		col2_byte = ROW_IDLE;

		if (flags.spacezap) begin
			// Starts, coin and two option switches
			col0_byte = {2'b11, ~p2.start, ~p1.start, dip_coin[1], 1'b1, ~p1.coin, 1'b1};
			col1_byte = {3'b111, p2_stick};
			// Option bit shares the p1 stick column
			col2_byte = {2'b11, dip_coin[0], p1_stick};
		end else if (flags.gorf) begin
			col0_byte = {dip_coin[2], dip_coin[0], ~p2.start, ~p1.start,
				1'b1, dip_coin[1], ~p1.coin, 1'b1};
			// Top two bits tied low on the Gorf harness
			col1_byte = {3'b001, p2_stick};
			// Speech chip busy on bit 7
			col2_byte = {speech_busy, 2'b01, p1_stick};
		end else if (flags.wow) begin
			col0_byte = {dip_coin[2], ~p2.start, ~p1.start, 1'b1,
				dip_coin[1], 1'b1, ~p1.coin, 1'b1};
			// Second button is read active high on this game
			col1_byte = {2'b11, ~p2.fire, p2.fire2, ~p2.right, ~p2.left, ~p2.down, ~p2.up};
			col2_byte = {speech_busy, 1'b1, ~p1.fire, p1.fire2,
				~p1.right, ~p1.left, ~p1.down, ~p1.up};
		end else if (flags.robby) begin
			col0_byte = {1'b0, ~p2.start, ~p1.start, 1'b1, dip_coin[1], 1'b1, ~p1.coin, 1'b1};
			// Unused bit 4 sits between fire and the directions
			col1_byte = {2'b11, ~p2.fire, 1'b1, ~p2.right, ~p2.left, ~p2.down, ~p2.up};
			col2_byte = {2'b11, ~p1.fire, 1'b1, ~p1.right, ~p1.left, ~p1.down, ~p1.up};
		end
	end

	// ====================
	// Column select
	// ====================

	// Strobe must be exactly one-hot, anything else floats high
	always_comb begin
		case (col_select)
			COL_0: row_data = col0_byte;
			COL_1: row_data = col1_byte;
			COL_2: row_data = col2_byte;
			// Every kept game reads a raw DIP byte here
			COL_3: row_data = any_game ? dips[DIP_EXTRA] : ROW_IDLE;
			default: row_data = ROW_IDLE;
		endcase
	end

endmodule

// ==== sound_mixer.sv ====
// Output side, picks and sums chip, speech and sample audio per game and cabinet layout
`timescale 1ns/1ps

module sound_mixer (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  game_pkg::game_flags_t flags,
	input  game_pkg::dip_bank_t   dips,
	input  io_pkg::audio_pair_t   chip_audio,
	input  io_pkg::audio_pair_t   sample_audio,
	input  logic                  speech_select,
	output io_pkg::audio_pair_t   audio_out
);
	import game_pkg::*;
	import io_pkg::*;

	logic        cabinet;
	logic [16:0] cab_sum;
	logic [15:0] cab_left;
	logic [15:0] mix_left;
	logic [15:0] mix_right;
	audio_pair_t audio_next;

	// Gorf upright cabinet with separate top and lower speakers
	assign cabinet = flags.gorf && dips[DIP_CAB][0];

	// ====================
	// Cabinet left channel
	// ====================

	// Chip silence sits at zero, samples idle at mid-scale
	// The offset brings the chip up near the halved sample level
	assign cab_sum  = {1'b0, chip_audio.left} + CAB_OFFSET;
	assign cab_left = (cab_sum > AUDIO_MAX) ? AUDIO_MAX[15:0] : cab_sum[15:0];

	// ====================
	// Half-sum mix
	// ====================

	// Two 15-bit halves never carry out of 16 bits
	assign mix_left  = {1'b0, chip_audio.left[15:1]} + {1'b0, sample_audio.left[15:1]};
	assign mix_right = {1'b0, chip_audio.right[15:1]} + {1'b0, sample_audio.right[15:1]};

	always_comb begin
		// Space Zap and no game, one chip on both sides
		audio_next.left  = chip_audio.left;
		audio_next.right = chip_audio.left;

		if (cabinet) begin
			// Top speaker is the right chip channel
			audio_next.right = chip_audio.right;
			// Lower speaker switches between speech and the second chip
			if (speech_select) begin
				audio_next.left = {1'b0, sample_audio.left[15:1]};
			end else begin
				audio_next.left = cab_left;
			end
		end else if (flags.gorf || flags.wow) begin
			// Chip plus speech samples
			audio_next.left  = mix_left;
			audio_next.right = mix_right;
		end else if (flags.robby) begin
			// Two sound chips, true stereo
			audio_next.right = chip_audio.right;
		end
	end

	// One cycle of latency to the outputs
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			audio_out <= '0;
		end else begin
			audio_out <= audio_next;
		end
	end

endmodule

// ==== arcade_io_top.sv ====
// Top level of the operator-control and sound-mixing block, connects capture, matrix and mixer
`timescale 1ns/1ps

module arcade_io_top (
	input  logic                clk_sys,
	input  logic                reset,
	input  io_pkg::download_t   dl,
	input  io_pkg::player_t     p1,
	input  io_pkg::player_t     p2,
	input  logic                speech_busy,
	input  logic [7:0]          col_select,
	input  logic                speech_select,
	input  io_pkg::audio_pair_t chip_audio,
	input  io_pkg::audio_pair_t sample_audio,
	output logic [7:0]          row_data,
	output io_pkg::audio_pair_t audio_out
);
	import game_pkg::*;

	// Decoded game and DIP state shared by both consumers
	game_flags_t flags;
	dip_bank_t   dips;

	// Host writes in
	download_capture u_capture (
		.clk_sys (clk_sys),
		.reset   (reset),
		.dl      (dl),
		.flags   (flags),
		.dips    (dips)
	);

	// CPU switch reads, no clock
	switch_matrix u_matrix (
		.flags       (flags),
		.dips        (dips),
		.p1          (p1),
		.p2          (p2),
		.speech_busy (speech_busy),
		.col_select  (col_select),
		.row_data    (row_data)
	);

	// Audio out
	sound_mixer u_mixer (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.flags         (flags),
		.dips          (dips),
		.chip_audio    (chip_audio),
		.sample_audio  (sample_audio),
		.speech_select (speech_select),
		.audio_out     (audio_out)
	);

endmodule

// ==== arcade_io_assertions.sv ====
// Bound checker for the arcade I/O top, models rows and audio from observed host writes
`timescale 1ns/1ps

module arcade_io_assertions (
	input logic                clk_sys,
	input logic                reset,
	input io_pkg::download_t   dl,
	input io_pkg::player_t     p1,
	input io_pkg::player_t     p2,
	input logic                speech_busy,
	input logic [7:0]          col_select,
	input logic                speech_select,
	input io_pkg::audio_pair_t chip_audio,
	input io_pkg::audio_pair_t sample_audio,
	input logic [7:0]          row_data,
	input io_pkg::audio_pair_t audio_out
);
	import game_pkg::*;
	import io_pkg::*;

	// Shadow code register, and the game it selects one edge later
	game_code_t  sh_code;
	game_code_t  sh_game;
	dip_bank_t   sh_dips;
	audio_pair_t exp_audio;
	logic [7:0]  exp_row;

	// ====================
	// Reference models
	// ====================

	// Row byte per game and strobe, bit 7 first, buttons active low
	function automatic logic [7:0] row_model(input game_code_t g, input dip_bank_t d,
		input player_t a, input player_t b, input logic busy, input logic [7:0] col);
		dip_byte_t       k;
		logic [2:0][7:0] c;
		k = d[DIP_COIN];
		c = {3{ROW_IDLE}};
		if (g == GAME_SPACEZAP) begin
			c[0] = {2'b11, ~b.start, ~a.start, k[1], 1'b1, ~a.coin, 1'b1};
			c[1] = {3'b111, ~b.fire, ~b.right, ~b.left, ~b.down, ~b.up};
			c[2] = {2'b11, k[0], ~a.fire, ~a.right, ~a.left, ~a.down, ~a.up};
		end else if (g == GAME_GORF) begin
			c[0] = {k[2], k[0], ~b.start, ~a.start, 1'b1, k[1], ~a.coin, 1'b1};
			c[1] = {3'b001, ~b.fire, ~b.right, ~b.left, ~b.down, ~b.up};
			c[2] = {busy, 2'b01, ~a.fire, ~a.right, ~a.left, ~a.down, ~a.up};
		end else if (g == GAME_WOW) begin
			c[0] = {k[2], ~b.start, ~a.start, 1'b1, k[1], 1'b1, ~a.coin, 1'b1};
			c[1] = {2'b11, ~b.fire, b.fire2, ~b.right, ~b.left, ~b.down, ~b.up};
			c[2] = {busy, 1'b1, ~a.fire, a.fire2, ~a.right, ~a.left, ~a.down, ~a.up};
		end else if (g == GAME_ROBBY) begin
			c[0] = {1'b0, ~b.start, ~a.start, 1'b1, k[1], 1'b1, ~a.coin, 1'b1};
			c[1] = {2'b11, ~b.fire, 1'b1, ~b.right, ~b.left, ~b.down, ~b.up};
			c[2] = {2'b11, ~a.fire, 1'b1, ~a.right, ~a.left, ~a.down, ~a.up};
		end
		case (col)
			COL_0: row_model = c[0];
			COL_1: row_model = c[1];
			COL_2: row_model = c[2];
			// Raw extra DIP byte for any kept game
			COL_3: row_model = (g inside {GAME_SPACEZAP, GAME_GORF, GAME_WOW, GAME_ROBBY}) ?
				d[DIP_EXTRA] : ROW_IDLE;
			default: row_model = ROW_IDLE;
		endcase
	endfunction

	// Mixer output for one set of inputs
	function automatic audio_pair_t mix_model(input game_code_t g, input logic cab,
		input audio_pair_t chip, input audio_pair_t smp, input logic sel);
		audio_pair_t r;
		logic [16:0] lifted;
		lifted  = {1'b0, chip.left} + CAB_OFFSET;
		r.left  = chip.left;
		r.right = chip.left;
		if (g == GAME_GORF && cab) begin
			r.right = chip.right;
			// Lower speaker, halved speech or lifted chip clipped at full scale
			r.left  = sel ? (smp.left >> 1) :
				((lifted > AUDIO_MAX) ? 16'hFFFF : lifted[15:0]);
		end else if (g == GAME_GORF || g == GAME_WOW) begin
			r.left  = (chip.left >> 1) + (smp.left >> 1);
			r.right = (chip.right >> 1) + (smp.right >> 1);
		end else if (g == GAME_ROBBY) begin
			r.right = chip.right;
		end
		return r;
	endfunction

	// Shadow state follows the same write strobes the DUT sees
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			sh_code   <= GAME_NONE;
			sh_game   <= GAME_NONE;
			sh_dips   <= '0;
			exp_audio <= '0;
		end else begin
			if (dl.wr && dl.index == IDX_GAME)
				sh_code <= dl.data;
			if (dl.wr && dl.index == IDX_DIP && dl.addr < 19'd8)
				sh_dips[dl.addr[2:0]] <= dl.data;
			// Program 1 Gorf plays as plain Gorf
			sh_game   <= (sh_code == GAME_GORF_PRG1) ? GAME_GORF : sh_code;
			exp_audio <= mix_model(sh_game, sh_dips[DIP_CAB][0], chip_audio, sample_audio,
				speech_select);
		end
	end

	assign exp_row = row_model(sh_game, sh_dips, p1, p2, speech_busy, col_select);

	// Sampled mid-cycle, after the rising-edge drive has settled
	row_check: assert property (@(negedge clk_sys) disable iff (reset) row_data == exp_row)
		else begin
			$error("Fail t=%0t row_data got %02h expected %02h", $time, row_data, exp_row);
			tb_arcade_io.error_count = tb_arcade_io.error_count + 1;
		end

	audio_check: assert property (@(negedge clk_sys) disable iff (reset) audio_out == exp_audio)
		else begin
			$error("Fail t=%0t audio_out got %08h expected %08h", $time, audio_out, exp_audio);
			tb_arcade_io.error_count = tb_arcade_io.error_count + 1;
		end

endmodule

// ==== tb_arcade_io.sv ====
// Testbench top for the arcade I/O block, drives writes, buttons and audio for the bound checker
`timescale 1ns/1ps

module tb_arcade_io;
	import game_pkg::*;
	import io_pkg::*;

	// Stimulus runs about 2000 cycles, the guard sits at twice that
	localparam int CYCLE_LIMIT = 4000;

	logic        clk_sys = 1'b0;
	logic        reset;
	download_t   dl;
	player_t     p1;
	player_t     p2;
	logic        speech_busy;
	logic        speech_select;
	logic [7:0]  col_select;
	audio_pair_t chip_audio;
	audio_pair_t sample_audio;
	logic [7:0]  row_data;
	audio_pair_t audio_out;

	// Bumped by the bound checker on each failed assertion
	int     error_count = 0;
	int     cycle_count = 0;
	integer seed;

	// Kept games, the Gorf program 1 code, then an unknown code
	game_code_t codes [6] = '{GAME_SPACEZAP, GAME_GORF, GAME_WOW, GAME_ROBBY,
		GAME_GORF_PRG1, 8'd9};

	arcade_io_top UUT (.*);

	bind arcade_io_top arcade_io_assertions u_checks (.*);

	// 100 ns clock
	always #50 clk_sys = ~clk_sys;

	// ====================
	// Stimulus tasks
	// ====================

	// One host write strobe, then the bus goes quiet
	task automatic write_host(input logic [7:0] idx, input logic [18:0] addr,
		input logic [7:0] data);
		@(posedge clk_sys);
		dl <= '{wr: 1'b1, index: idx, addr: addr, data: data};
		@(posedge clk_sys);
		dl <= '0;
	endtask

	// New random buttons, strobe and audio on every clock
	task automatic sweep_columns(input int cycles);
		logic [31:0] rnd;
		for (int i = 0; i < cycles; i++) begin
			@(posedge clk_sys);
			rnd = $random(seed);
			p1            <= rnd[7:0];
			p2            <= rnd[15:8];
			speech_busy   <= rnd[16];
			speech_select <= rnd[17];
			// Columns 0 to 3 in turn, then a stray strobe that is often multi-hot
			col_select    <= (i % 5 == 4) ? rnd[31:24] : 8'(1 << (i % 5));
			chip_audio    <= $random(seed);
			sample_audio  <= $random(seed);
		end
	endtask

	// ====================
	// Run guard
	// ====================

	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Timeout, stimulus still running after %0d cycles", CYCLE_LIMIT);
			$display("Errors: %0d assertion failures in %0d cycles", error_count, cycle_count);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	// ====================
	// Main sequence
	// ====================

	initial begin
		logic [31:0] rnd;
		seed          = 32'h4a45_ea0a;
		reset         <= 1'b1;
		dl            <= '0;
		p1            <= '0;
		p2            <= '0;
		speech_busy   <= 1'b0;
		speech_select <= 1'b0;
		col_select    <= ROW_IDLE;
		chip_audio    <= '0;
		sample_audio  <= '0;
		repeat (16) @(posedge clk_sys);
		reset <= 1'b0;

		// No game yet, rows idle and chip left on both sides
		sweep_columns(40);

		foreach (codes[g]) begin
			write_host(IDX_GAME, 19'd0, codes[g]);
			// Both cabinet layouts with a fresh DIP bank each
			for (int cab = 0; cab < 2; cab++) begin
				for (int a = 0; a < DIP_COUNT; a++) begin
					rnd = $random(seed);
					rnd[0] = (a == DIP_CAB) ? cab[0] : rnd[0];
					write_host(IDX_DIP, 19'(a), rnd[7:0]);
				end
				sweep_columns(120);
			end
			// Past the bank, high address with low bits in range, foreign index
			// Taking the first one would clear the Gorf cabinet bit left set above
			write_host(IDX_DIP, 19'd8, 8'hA4);
			write_host(IDX_DIP, 19'h40003, 8'h5A);
			write_host(8'd2, 19'd3, 8'h3C);
			sweep_columns(20);
		end

		// Let the last registered audio reach a check
		repeat (4) @(posedge clk_sys);
		$display("Errors: %0d assertion failures in %0d cycles", error_count, cycle_count);
		if (error_count == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

// ==== compile.f ====
game_pkg.sv
io_pkg.sv
download_capture.sv
switch_matrix.sv
sound_mixer.sv
arcade_io_top.sv
arcade_io_assertions.sv
tb_arcade_io.sv

// ==== Makefile ====
TOP       ?= tb_arcade_io
VERILATOR ?= verilator
VFLAGS    ?= --binary --assertions -j 0
SIMFLAGS  ?= +verilator+error+limit+100000
OBJ_DIR   ?= obj_dir
PASS_MSG  := PASS: all tests

.PHONY: help test clean

help:
	@echo "make help   list these targets"
	@echo "make test   build with Verilator, run, pass only if the pass line is printed"
	@echo "make clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f compile.f
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIMFLAGS))"; echo "$$out"; \
		echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(OBJ_DIR)
